/* hdl/md5Pkg.sv */
`default_nettype none

package md5Pkg;

  parameter int WordWidth = 32;
  parameter int ChunkWords = 16;
  parameter int NumSteps = 64;

  typedef logic [WordWidth-1:0] md5Word;

  typedef struct packed {
    md5Word a;
    md5Word b;
    md5Word c;
    md5Word d;
  } md5State;

  // word 0 sits in the lowest 32 bits.
  typedef md5Word [ChunkWords-1:0] md5Chunk;

  typedef struct packed {
    md5State state;
    md5Chunk chunk;
  } md5Job;

  // floor(abs(sin(i + 1)) * 2^32) for each step.
  localparam md5Word ConstTable [NumSteps] = '{
    32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
    32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
    32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
    32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
    32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
    32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
    32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
    32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
    32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
    32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
    32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
    32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
    32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
    32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
    32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
    32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
  };

  // four rotate amounts per round.
  localparam int ShiftTable [16] = '{
    7, 12, 17, 22,
    5, 9, 14, 20,
    4, 11, 16, 23,
    6, 10, 15, 21
  };

  function automatic md5Word stepConstant(input int stepIdx);
    return ConstTable[stepIdx];
  endfunction

  function automatic int stepShift(input int stepIdx);
    return ShiftTable[(stepIdx / 16) * 4 + (stepIdx % 4)];
  endfunction

  function automatic int stepWordIndex(input int stepIdx);
    case (stepIdx / 16)
      0:
      begin
        return stepIdx;
      end
      1:
      begin
        return (5 * stepIdx + 1) % 16;
      end
      2:
      begin
        return (3 * stepIdx + 5) % 16;
      end
      default:
      begin
        return (7 * stepIdx) % 16;
      end
    endcase
  endfunction

  // F, G, H and I by round.
  function automatic md5Word roundMix(input int stepIdx, input md5Word b, input md5Word c,
                                      input md5Word d);
    case (stepIdx / 16)
      0:
      begin
        return (b & c) | (~b & d);
      end
      1:
      begin
        return (d & b) | (~d & c);
      end
      2:
      begin
        return b ^ c ^ d;
      end
      default:
      begin
        return c ^ (b | ~d);
      end
    endcase
  endfunction

endpackage

`default_nettype wire

/* hdl/md5Step.sv */
`timescale 1ns/1ns
`default_nettype none

module md5Step #(
  parameter int StepIdx = 0
) (
  input  logic          clk,
  input  logic          rstN,
  input  logic          inValid,
  input  md5Pkg::md5Job inJob,
  output logic          outValid,
  output md5Pkg::md5Job outJob
);

  localparam md5Pkg::md5Word StepConst = md5Pkg::stepConstant(StepIdx);
  localparam int ShiftAmt = md5Pkg::stepShift(StepIdx);
  localparam int WordIdx = md5Pkg::stepWordIndex(StepIdx);

  md5Pkg::md5Word mixSum;
  md5Pkg::md5Word rotated;
  md5Pkg::md5Word nextB;

  assign mixSum = inJob.state.a
                + md5Pkg::roundMix(StepIdx, inJob.state.b, inJob.state.c, inJob.state.d)
                + StepConst
                + inJob.chunk[WordIdx];

  assign rotated = (mixSum << ShiftAmt) | (mixSum >> (md5Pkg::WordWidth - ShiftAmt));
  assign nextB = inJob.state.b + rotated;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= inValid;
    end
  end

  always_ff @(posedge clk)
  begin
    outJob.state <= '{a: inJob.state.d, b: nextB, c: inJob.state.b, d: inJob.state.c};
    outJob.chunk <= inJob.chunk; // chunk rides along unchanged.
  end

endmodule

`default_nettype wire

/* hdl/md5Pipeline.sv */
`timescale 1ns/1ns
`default_nettype none

module md5Pipeline (
  input  logic            clk,
  input  logic            rstN,
  input  logic            inValid,
  input  md5Pkg::md5Job   inJob,
  output logic            outValid,
  output md5Pkg::md5State outState
);

  // index 0 is the input, index NumSteps the last step's registers.
  logic          stageValid [md5Pkg::NumSteps+1];
  md5Pkg::md5Job stageJob [md5Pkg::NumSteps+1];

  assign stageValid[0] = inValid;
  assign stageJob[0] = inJob;

  for (genvar i = 0; i < md5Pkg::NumSteps; i++)
  begin : gStep
    md5Step #(
      .StepIdx (i)
    ) md5Step_inst (
      .clk      (clk),
      .rstN     (rstN),
      .inValid  (stageValid[i]),
      .inJob    (stageJob[i]),
      .outValid (stageValid[i+1]),
      .outJob   (stageJob[i+1])
    );
  end

  assign outValid = stageValid[md5Pkg::NumSteps];
  assign outState = stageJob[md5Pkg::NumSteps].state; // chunk ends here.

endmodule

`default_nettype wire

/* hdl/md5ResultBuffer.sv */
`timescale 1ns/1ns
`default_nettype none

module md5ResultBuffer #(
  parameter int BufDepth = 8
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            pushValid,
  input  md5Pkg::md5State pushState,
  input  logic            outCredit,
  output logic            outValid,
  output md5Pkg::md5State outState,
  output logic            inCredit
);

  localparam int PtrWidth = $clog2(BufDepth);
  localparam int CountWidth = $clog2(BufDepth + 1);
  localparam int CreditWidth = 16;

  md5Pkg::md5State mem [BufDepth];

  logic [PtrWidth-1:0]    wrPtr;
  logic [PtrWidth-1:0]    rdPtr;
  logic [CountWidth-1:0]  fillCount;
  logic [CreditWidth-1:0] creditCount;
  logic                   pop;

  assign pop = (fillCount != '0) && (creditCount != '0);

  always_ff @(posedge clk)
  begin
    if (pushValid)
    begin
      mem[wrPtr] <= pushState;
    end
    if (pop)
    begin
      outState <= mem[rdPtr];
    end
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      fillCount <= '0;
      creditCount <= '0;
      outValid <= 1'b0;
      inCredit <= 1'b0;
    end
    else
    begin
      if (pushValid)
      begin
        wrPtr <= (wrPtr == PtrWidth'(BufDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop)
      begin
        rdPtr <= (rdPtr == PtrWidth'(BufDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      fillCount <= fillCount + CountWidth'(pushValid) - CountWidth'(pop);
      creditCount <= creditCount + CreditWidth'(outCredit) - CreditWidth'(pop);
      outValid <= pop;
      inCredit <= outValid; // slot returned the cycle after transfer.
    end
  end

endmodule

`default_nettype wire

/* hdl/md5Core.sv */
`timescale 1ns/1ns
`default_nettype none

module md5Core #(
  parameter int BufDepth = 8
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            inValid,
  input  md5Pkg::md5Job   inJob,
  output logic            inCredit,
  output logic            outValid,
  output md5Pkg::md5State outState,
  input  logic            outCredit
);

  logic            pipeValid;
  md5Pkg::md5State pipeState;

  md5Pipeline md5Pipeline_inst (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .inJob    (inJob),
    .outValid (pipeValid),
    .outState (pipeState)
  );

  // sized so every job in flight has a slot.
  md5ResultBuffer #(
    .BufDepth (BufDepth)
  ) md5ResultBuffer_inst (
    .clk       (clk),
    .rstN      (rstN),
    .pushValid (pipeValid),
    .pushState (pipeState),
    .outCredit (outCredit),
    .outValid  (outValid),
    .outState  (outState),
    .inCredit  (inCredit)
  );

endmodule

`default_nettype wire

/* test/md5Core_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module md5CoreAssertions #(
  parameter int BufDepth = 8,
  parameter int CountWidth = 4,
  parameter int CreditWidth = 16
) (
  input logic                  clk,
  input logic                  rstN,
  input logic [CountWidth-1:0] fillCount,
  input logic                  outCredit,
  input logic                  outValid,
  input logic                  inCredit
);

  logic [CreditWidth-1:0] grantsLeft; // grants seen minus transfers seen.

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      grantsLeft <= '0;
    end
    else
    begin
      grantsLeft <= grantsLeft + CreditWidth'(outCredit) - CreditWidth'(outValid);
    end
  end

  fillBound: assert property (@(posedge clk) disable iff (!rstN)
    fillCount <= CountWidth'(BufDepth))
    else $error("result buffer fill count above its depth");

  // a transfer needs a grant not yet used up.
  creditHeld: assert property (@(posedge clk) disable iff (!rstN)
    outValid |-> grantsLeft != '0)
    else $error("outValid raised without a held downstream credit");

  resetQuiet: assert property (@(posedge clk)
    !rstN |-> (!outValid && !inCredit))
    else $error("outValid or inCredit high during reset");

endmodule

bind md5ResultBuffer md5CoreAssertions #(
  .BufDepth    (BufDepth),
  .CountWidth  (CountWidth),
  .CreditWidth (CreditWidth)
) md5CoreAssertions_inst (
  .clk       (clk),
  .rstN      (rstN),
  .fillCount (fillCount),
  .outCredit (outCredit),
  .outValid  (outValid),
  .inCredit  (inCredit)
);

`default_nettype wire

/* test/md5CoreTb.sv */
`timescale 1ns/1ns
`default_nettype none

module md5CoreTb;

  localparam int BufDepth = 8;
  localparam int NumVectors = 6;
  localparam int VecWords = 24;
  localparam string VectorFile = "test/md5Vectors.hex";
  localparam int StreamCycles = NumVectors * 4 + md5Pkg::NumSteps + 200;
  // single-vector pass plus full-rate pass plus a double-length random pass.
  localparam int TimeoutCycles = NumVectors * (md5Pkg::NumSteps + 10) + 3 * StreamCycles;

  logic            clk;
  logic            rstN;
  logic            inValid;
  md5Pkg::md5Job   inJob;
  logic            inCredit;
  logic            outValid;
  md5Pkg::md5State outState;
  logic            outCredit;

  logic [31:0]     vecWords [NumVectors*VecWords];
  md5Pkg::md5State expQ [$];
  logic [31:0]     lfsrState = 32'h9958_5d86;
  int              creditMode = 0; // 0 none, 1 every cycle, 2 random.
  int              errorCount = 0;
  int              jobsSent = 0;
  int              jobsSeen = 0;
  int              received = 0;
  int              creditsGranted = 0;
  int              inCreditCount = 0;

  md5Core #(
    .BufDepth (BufDepth)
  ) md5Core_inst (
    .clk       (clk),
    .rstN      (rstN),
    .inValid   (inValid),
    .inJob     (inJob),
    .inCredit  (inCredit),
    .outValid  (outValid),
    .outState  (outState),
    .outCredit (outCredit)
  );

  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'h8020_0003;
    return state >> 1;
  endfunction

  task automatic nextRandomBit(output logic bitOut);
    lfsrState = lfsrStep(lfsrState);
    bitOut = lfsrState[0];
  endtask

  task automatic checkValue(input string name, input logic [127:0] actual,
                            input logic [127:0] expected);
    if (actual !== expected)
    begin
      errorCount++;
      $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic reportError(input string msg);
    errorCount++;
    $display("ERROR: %s at %0t ns", msg, $time);
  endtask

  function automatic md5Pkg::md5Job buildJob(input int idx);
    md5Pkg::md5Job job;
    for (int w = 0; w < md5Pkg::ChunkWords; w++)
    begin
      job.chunk[w] = vecWords[idx * VecWords + w];
    end
    job.state.a = vecWords[idx * VecWords + 16];
    job.state.b = vecWords[idx * VecWords + 17];
    job.state.c = vecWords[idx * VecWords + 18];
    job.state.d = vecWords[idx * VecWords + 19];
    return job;
  endfunction

  function automatic md5Pkg::md5State expectedState(input int idx);
    md5Pkg::md5State st;
    st.a = vecWords[idx * VecWords + 20];
    st.b = vecWords[idx * VecWords + 21];
    st.c = vecWords[idx * VecWords + 22];
    st.d = vecWords[idx * VecWords + 23];
    return st;
  endfunction

  function automatic int creditsHeld();
    return BufDepth - jobsSent + inCreditCount;
  endfunction

  // called at 1 ns after an edge, returns 1 ns after the accepting edge.
  task automatic sendJob(input int idx);
    while (creditsHeld() == 0)
    begin
      inValid = 1'b0;
      @(posedge clk);
      #1;
    end
    inValid = 1'b1;
    inJob = buildJob(idx);
    expQ.push_back(expectedState(idx));
    jobsSent++;
    @(posedge clk);
    #1;
  endtask

  task automatic waitDrained();
    while (received != jobsSent)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic setCreditMode(input int mode);
    @(negedge clk);
    creditMode = mode;
    @(posedge clk);
    #1;
  endtask

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #2 clk = ~clk;
    end
  end

  // sink grants only for jobs already sent, so no credits pile up.
  initial
  begin : sink
    logic grant;
    logic bitA;
    logic bitB;
    outCredit = 1'b0;
    forever
    begin
      @(posedge clk);
      #1;
      grant = 1'b0;
      if (rstN && creditsGranted < jobsSeen)
      begin
        if (creditMode == 1)
          grant = 1'b1;
        else if (creditMode == 2 && creditsGranted == received)
        begin
          // one grant out at a time, so results back up in the buffer.
          nextRandomBit(bitA);
          nextRandomBit(bitB);
          grant = bitA & bitB;
        end
      end
      outCredit = grant;
      if (grant)
        creditsGranted++;
    end
  end

  initial
  begin : monitor
    md5Pkg::md5State expState;
    forever
    begin
      @(negedge clk);
      if (rstN)
      begin
        if (inValid)
          jobsSeen++;
        if (inCredit)
          inCreditCount++;
        if (outValid)
        begin
          received++;
          if (expQ.size() == 0)
            reportError("result arrived with no job outstanding");
          else
          begin
            expState = expQ.pop_front();
            checkValue("outState", outState, expState);
          end
        end
        if (received > creditsGranted)
          reportError("more results than downstream credits granted");
        if (BufDepth - jobsSeen + inCreditCount < 0)
          reportError("upstream sent a job without holding a credit");
      end
    end
  end

  initial
  begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("ERROR: timeout after %0d cycles with results still missing", TimeoutCycles);
    $display("Test failures found");
    $finish;
  end

  initial
  begin
    rstN = 1'b0;
    inValid = 1'b0;
    inJob = '0;
    $readmemh(VectorFile, vecWords);

    repeat (4)
    begin
      @(posedge clk);
      #1;
      checkValue("outValid", 128'(outValid), 128'(0));
      checkValue("inCredit", 128'(inCredit), 128'(0));
    end
    rstN = 1'b1;
    @(negedge clk);
    checkValue("outValid", 128'(outValid), 128'(0)); // first cycle out of reset.
    checkValue("inCredit", 128'(inCredit), 128'(0));
    @(posedge clk);
    #1;

    setCreditMode(1);
    for (int i = 0; i < NumVectors; i++)
    begin
      sendJob(i);
      inValid = 1'b0;
      waitDrained();
    end

    for (int i = 0; i < NumVectors; i++)
    begin
      sendJob(i);
    end
    inValid = 1'b0;
    waitDrained();

    // twice the vectors, more than BufDepth, so the driver runs out of credits.
    setCreditMode(2);
    for (int r = 0; r < 2; r++)
    begin
      for (int i = 0; i < NumVectors; i++)
      begin
        sendJob(i);
      end
    end
    inValid = 1'b0;
    waitDrained();

    repeat (4) @(posedge clk);
    checkValue("inCreditCount", 128'(inCreditCount), 128'(received));
    checkValue("upstreamCredits", 128'(creditsHeld()), 128'(BufDepth));
    if (expQ.size() != 0)
      reportError("expected results never arrived");

    $display("%0d errors, %0d results received, %0d credits returned",
             errorCount, received, inCreditCount);
    if (errorCount == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hdl/md5Pkg.sv
hdl/md5Step.sv
hdl/md5Pipeline.sv
hdl/md5ResultBuffer.sv
hdl/md5Core.sv
test/md5Core_assertions.sv
test/md5CoreTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = md5CoreTb
FILELIST  = src.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* test/md5Vectors.hex */
// columns: chunk words 0..15, start a b c d, expected a b c d after step 64
// one vector per line, word 0 of the chunk first
// empty message
00000080 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 67452301 efcdab89 98badcfe 10325476 7246fad3 14e45506 ff4ea3eb 6e10a476
// "a"
00008061 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000008 00000000 67452301 efcdab89 98badcfe 10325476 52309e0b b8e94637 49dee633 50f422f3
// "abc"
80636261 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000018 00000000 67452301 efcdab89 98badcfe 10325476 310ade8f c08226b3 e484b9d8 624d8cb2
// "message digest"
7373656d 20656761 65676964 00807473 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000070 00000000 67452301 efcdab89 98badcfe 10325476 162448f8 9dc60bf3 98747d54 c02f9d34
// lower-case alphabet
64636261 68676665 6c6b6a69 706f6e6d 74737271 78777675 00807a79 00000000 00000000 00000000 00000000 00000000 00000000 00000000 000000d0 00000000 67452301 efcdab89 98badcfe 10325476 708ed9c2 1116e6d8 d38f1e7f 2baf1354
// "The quick brown fox jumps over the lazy dog"
20656854 63697571 7262206b 206e776f 20786f66 706d756a 766f2073 74207265 6c206568 20797a61 80676f64 00000000 00000000 00000000 00000158 00000000 67452301 efcdab89 98badcfe 10325476 3637ed9d 92e87fae 9c62fb6d c5e74fcc
